// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - hdl/cpuPkg.sv
  - hdl/fetchUnit.sv
  - hdl/decodeStage.sv
  - hdl/regFileBypass.sv
  - hdl/aluCore.sv
  - hdl/shiftUnit.sv
  - hdl/writebackStage.sv
  - hdl/cpuCore.sv
  - target: simulation
    files:
      - sim/cpuCore_assert.sv
      - sim/cpuChecker.sv
      - sim/cpuTb.sv

// ==== hdl/aluCore.sv ====
/* Add, subtract, xor and and-not on the execute operands */
module aluCore (
	input  cpuPkg::exOp_t                idEx,
	output logic [cpuPkg::DataWidth-1:0] aluResult
);

	cpuPkg::aluFunc_t fn;

	assign fn = cpuPkg::aluFunc_t'(idEx.func);

	always_comb begin
		case (fn)
			cpuPkg::Add: begin
				aluResult = idEx.opA + idEx.opB;
			end
			// SUB and SUBI both take the first operand away
			cpuPkg::Sub: begin
				aluResult = idEx.subFromB ? idEx.opB - idEx.opA : idEx.opA - idEx.opB;
			end
			cpuPkg::Xor: begin
				aluResult = idEx.opA ^ idEx.opB;
			end
			default: begin
				aluResult = idEx.opA & ~idEx.opB;
			end
		endcase
	end

endmodule

// ==== hdl/cpuCore.sv ====
/* Top level of the pipelined integer core, stage instances only */
module cpuCore (
	input  logic              clk,
	input  logic              arstN,
	output cpuPkg::wbReq_t    ibusReq,
	input  cpuPkg::wbRsp_t    ibusRsp,
	output cpuPkg::retire_t   retire
);

	cpuPkg::instr_t                  ifId;
	logic                            ifIdValid;
	cpuPkg::exOp_t                   idEx;
	cpuPkg::exResult_t               exResult;
	logic [cpuPkg::RegAddrWidth-1:0] rdAddrA;
	logic [cpuPkg::RegAddrWidth-1:0] rdAddrB;
	logic [cpuPkg::DataWidth-1:0]    rdDataA;
	logic [cpuPkg::DataWidth-1:0]    rdDataB;
	logic                            wrEn;
	logic [cpuPkg::RegAddrWidth-1:0] wrAddr;
	logic [cpuPkg::DataWidth-1:0]    wrData;
	logic [cpuPkg::DataWidth-1:0]    aluResult;
	logic [cpuPkg::DataWidth-1:0]    shiftResult;

	fetchUnit fetch_i (.clk, .arstN, .ibusReq, .ibusRsp, .ifId, .ifIdValid);

	decodeStage decode_i (
		.clk, .arstN, .ifId, .ifIdValid,
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.exResult, .idEx
	);

	regFileBypass regFile_i (
		.clk, .arstN, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.wrEn, .wrAddr, .wrData
	);

	// Both units see every ID/EX op, writeback picks one
	aluCore alu_i (.idEx, .aluResult);
	shiftUnit shift_i (.idEx, .shiftResult);

	writebackStage writeback_i (
		.clk, .arstN, .idEx, .aluResult, .shiftResult,
		.exResult, .wrEn, .wrAddr, .wrData, .retire
	);

endmodule

// ==== hdl/cpuPkg.sv ====
/* Shared widths, opcodes and function codes of the integer core,
   plus the bus, instruction, pipeline stage and retire structs */
package cpuPkg;

	localparam int DataWidth    = 16;
	localparam int RegAddrWidth = 3;
	localparam int NumRegs      = 8;
	localparam int PcStep       = 2;
	localparam int OpcodeWidth  = 5;

	// Opcodes kept by the core
	localparam logic [OpcodeWidth-1:0] OpNop      = 5'b00001;
	localparam logic [OpcodeWidth-1:0] OpAddi     = 5'b01000;
	localparam logic [OpcodeWidth-1:0] OpSubi     = 5'b01001;
	localparam logic [OpcodeWidth-1:0] OpXori     = 5'b01010;
	localparam logic [OpcodeWidth-1:0] OpAndni    = 5'b01011;
	localparam logic [OpcodeWidth-1:0] OpRoli     = 5'b10100;
	localparam logic [OpcodeWidth-1:0] OpSlli     = 5'b10101;
	localparam logic [OpcodeWidth-1:0] OpRori     = 5'b10110;
	localparam logic [OpcodeWidth-1:0] OpSrli     = 5'b10111;
	localparam logic [OpcodeWidth-1:0] OpLbi      = 5'b11000;
	localparam logic [OpcodeWidth-1:0] OpAluReg   = 5'b11011;
	localparam logic [OpcodeWidth-1:0] OpShiftReg = 5'b11010;

	// Same encoding as the func field of the register forms
	typedef enum logic [1:0] {Add = 2'b00, Sub = 2'b01, Xor = 2'b10, AndN = 2'b11} aluFunc_t;
	typedef enum logic [1:0] {Rol = 2'b00, Sll = 2'b01, Ror = 2'b10, Srl = 2'b11} shiftFunc_t;

	typedef struct packed {
		logic [OpcodeWidth-1:0]  opcode;
		logic [RegAddrWidth-1:0] rs;
		logic [RegAddrWidth-1:0] rt;
		logic [RegAddrWidth-1:0] rd;
		logic [1:0]              func;
	} instr_t;

	// Wishbone classic, read-only master
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic [DataWidth-1:0] adr;
	} wbReq_t;

	typedef struct packed {
		logic                 ack;
		logic [DataWidth-1:0] dat;
	} wbRsp_t;

	typedef struct packed {
		logic                    valid;
		logic                    regWrite;
		logic [RegAddrWidth-1:0] dest;
		logic                    useShift;
		logic [1:0]              func;      // aluFunc_t or shiftFunc_t
		logic                    subFromB;
		logic [DataWidth-1:0]    opA;
		logic [DataWidth-1:0]    opB;
	} exOp_t;

	typedef struct packed {
		logic                    valid;
		logic                    regWrite;
		logic [RegAddrWidth-1:0] dest;
		logic [DataWidth-1:0]    data;
	} exResult_t;

	typedef struct packed {
		logic                    valid;
		logic [RegAddrWidth-1:0] rd;
		logic [DataWidth-1:0]    data;
	} retire_t;

endpackage

// ==== hdl/decodeStage.sv ====
/* Opcode decode, immediate extension and operand forwarding,
   registered into the ID/EX stage */
module decodeStage (
	input  logic                              clk,
	input  logic                              arstN,
	input  cpuPkg::instr_t                    ifId,
	input  logic                              ifIdValid,
	output logic [cpuPkg::RegAddrWidth-1:0]   rdAddrA,
	output logic [cpuPkg::RegAddrWidth-1:0]   rdAddrB,
	input  logic [cpuPkg::DataWidth-1:0]      rdDataA,
	input  logic [cpuPkg::DataWidth-1:0]      rdDataB,
	input  cpuPkg::exResult_t                 exResult,
	output cpuPkg::exOp_t                     idEx
);

	logic [cpuPkg::DataWidth-1:0]    instrBits;
	logic [cpuPkg::DataWidth-1:0]    imm;
	logic [cpuPkg::DataWidth-1:0]    fwdA;
	logic [cpuPkg::DataWidth-1:0]    fwdB;
	logic [cpuPkg::RegAddrWidth-1:0] dest;
	logic [1:0]                      func;
	logic                            regWrite;
	logic                            useShift;
	logic                            subFromB;
	logic                            useRegB;
	logic                            zeroA;
	logic                            exHit;
	cpuPkg::exOp_t                   idExNext;

	assign instrBits = ifId;
	assign rdAddrA   = ifId.rs;
	assign rdAddrB   = ifId.rt;

	always_comb begin
		regWrite = 1'b0;
		useShift = 1'b0;
		subFromB = 1'b0;
		useRegB  = 1'b0;
		zeroA    = 1'b0;
		func     = ifId.func;
		dest     = ifId.rt;
		imm      = '0;
		case (ifId.opcode)
			cpuPkg::OpAddi, cpuPkg::OpSubi: begin
				regWrite = 1'b1;
				func     = ifId.opcode[1:0];
				subFromB = ifId.opcode == cpuPkg::OpSubi;
				imm      = {{(cpuPkg::DataWidth-5){instrBits[4]}}, instrBits[4:0]};
			end
			cpuPkg::OpXori, cpuPkg::OpAndni: begin
				regWrite = 1'b1;
				func     = ifId.opcode[1:0];
				imm      = {{(cpuPkg::DataWidth-5){1'b0}}, instrBits[4:0]};
			end
			// Low opcode bits already give the shift code
			cpuPkg::OpRoli, cpuPkg::OpSlli, cpuPkg::OpRori, cpuPkg::OpSrli: begin
				regWrite = 1'b1;
				useShift = 1'b1;
				func     = ifId.opcode[1:0];
				imm      = {{(cpuPkg::DataWidth-4){1'b0}}, instrBits[3:0]};
			end
			cpuPkg::OpLbi: begin
				regWrite = 1'b1;
				func     = cpuPkg::Add;
				dest     = ifId.rs;
				zeroA    = 1'b1;
				imm      = {{(cpuPkg::DataWidth-8){instrBits[7]}}, instrBits[7:0]};
			end
			cpuPkg::OpAluReg: begin
				regWrite = 1'b1;
				useRegB  = 1'b1;
				dest     = ifId.rd;
				// SUB is Rt minus Rs
				subFromB = ifId.func == cpuPkg::Sub;
			end
			cpuPkg::OpShiftReg: begin
				regWrite = 1'b1;
				useShift = 1'b1;
				useRegB  = 1'b1;
				dest     = ifId.rd;
			end
			// NOP and every other opcode write nothing
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

	// Execute result wins, writeback value arrives through the register file bypass
	assign exHit = exResult.valid && exResult.regWrite;
	assign fwdA  = (exHit && exResult.dest == ifId.rs) ? exResult.data : rdDataA;
	assign fwdB  = (exHit && exResult.dest == ifId.rt) ? exResult.data : rdDataB;

	always_comb begin
		idExNext.valid    = ifIdValid;
		idExNext.regWrite = ifIdValid && regWrite;
		idExNext.dest     = dest;
		idExNext.useShift = useShift;
		idExNext.func     = func;
		idExNext.subFromB = subFromB;
		idExNext.opA      = zeroA ? '0 : fwdA;
		idExNext.opB      = useRegB ? fwdB : imm;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else begin
			idEx <= idExNext;
		end
	end

endmodule

// ==== hdl/fetchUnit.sv ====
/* Instruction fetch: Wishbone classic read master, program counter
   and the IF/ID register */
module fetchUnit (
	input  logic             clk,
	input  logic             arstN,
	output cpuPkg::wbReq_t   ibusReq,
	input  cpuPkg::wbRsp_t   ibusRsp,
	output cpuPkg::instr_t   ifId,
	output logic             ifIdValid
);

	logic                         reqActive;
	logic [cpuPkg::DataWidth-1:0] pc;
	logic                         accept;

	// Word is taken on any edge with ack during an active request
	assign accept = reqActive && ibusRsp.ack;

	// One idle cycle after reset, then the request never drops
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			reqActive <= 1'b0;
			pc        <= '0;
			ifIdValid <= 1'b0;
		end else begin
			reqActive <= 1'b1;
			ifIdValid <= accept;
			if (accept) begin
				pc <= pc + cpuPkg::DataWidth'(cpuPkg::PcStep);
			end
		end
	end

	// IF/ID payload, only meaningful with ifIdValid
	always_ff @(posedge clk) begin
		if (accept) begin
			ifId <= cpuPkg::instr_t'(ibusRsp.dat);
		end
	end

	always_comb begin
		ibusReq.cyc = reqActive;
		ibusReq.stb = reqActive;
		ibusReq.adr = pc;
	end

endmodule

// ==== hdl/regFileBypass.sv ====
/* Eight-entry register file with two read ports, one write port
   and a same-cycle write-to-read bypass */
module regFileBypass (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic [cpuPkg::RegAddrWidth-1:0]   rdAddrA,
	input  logic [cpuPkg::RegAddrWidth-1:0]   rdAddrB,
	output logic [cpuPkg::DataWidth-1:0]      rdDataA,
	output logic [cpuPkg::DataWidth-1:0]      rdDataB,
	input  logic                              wrEn,
	input  logic [cpuPkg::RegAddrWidth-1:0]   wrAddr,
	input  logic [cpuPkg::DataWidth-1:0]      wrData
);

	logic [cpuPkg::DataWidth-1:0] regs [cpuPkg::NumRegs];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write in flight is visible to decode this cycle
	assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== hdl/shiftUnit.sv ====
/* Rotate and logical shift of operand A by 0 to 15 places */
module shiftUnit (
	input  cpuPkg::exOp_t                idEx,
	output logic [cpuPkg::DataWidth-1:0] shiftResult
);

	cpuPkg::shiftFunc_t fn;
	logic [3:0]         amt;

	assign fn  = cpuPkg::shiftFunc_t'(idEx.func);
	assign amt = idEx.opB[3:0];

	// Shift by the full width yields zero, so amt of 0 rotates cleanly
	always_comb begin
		case (fn)
			cpuPkg::Rol: shiftResult = (idEx.opA << amt) | (idEx.opA >> (cpuPkg::DataWidth - amt));
			cpuPkg::Sll: shiftResult = idEx.opA << amt;
			cpuPkg::Ror: shiftResult = (idEx.opA >> amt) | (idEx.opA << (cpuPkg::DataWidth - amt));
			default:     shiftResult = idEx.opA >> amt;
		endcase
	end

endmodule

// ==== hdl/writebackStage.sv ====
/* Execute result select, EX/WB register, register write port
   and the retire port */
module writebackStage (
	input  logic                              clk,
	input  logic                              arstN,
	input  cpuPkg::exOp_t                     idEx,
	input  logic [cpuPkg::DataWidth-1:0]      aluResult,
	input  logic [cpuPkg::DataWidth-1:0]      shiftResult,
	output cpuPkg::exResult_t                 exResult,
	output logic                              wrEn,
	output logic [cpuPkg::RegAddrWidth-1:0]   wrAddr,
	output logic [cpuPkg::DataWidth-1:0]      wrData,
	output cpuPkg::retire_t                   retire
);

	cpuPkg::exResult_t wbReg;

	// Also the forwarding source from execute
	always_comb begin
		exResult.valid    = idEx.valid;
		exResult.regWrite = idEx.regWrite;
		exResult.dest     = idEx.dest;
		exResult.data     = idEx.useShift ? shiftResult : aluResult;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbReg <= '0;
		end else begin
			wbReg <= exResult;
		end
	end

	assign wrEn   = wbReg.valid && wbReg.regWrite;
	assign wrAddr = wbReg.dest;
	assign wrData = wbReg.data;

	// Only register writes retire
	assign retire = '{valid: wrEn, rd: wbReg.dest, data: wbReg.data};

endmodule

// ==== list.f ====
hdl/cpuPkg.sv
hdl/fetchUnit.sv
hdl/decodeStage.sv
hdl/regFileBypass.sv
hdl/aluCore.sv
hdl/shiftUnit.sv
hdl/writebackStage.sv
hdl/cpuCore.sv
sim/cpuCore_assert.sv
sim/cpuChecker.sv
sim/cpuTb.sv

// ==== sim/cpuChecker.sv ====
/* Retire port monitor, compares each retire with the expected list */
module cpuChecker #(
	parameter int NumExp = 1
) (
	input  logic            clk,
	input  logic            arstN,
	input  cpuPkg::retire_t retire,
	input  cpuPkg::retire_t expRet [NumExp],
	output int              seen,
	output int              errors
);

	logic rowOk;

	initial begin
		seen   = 0;
		errors = 0;
	end

	always @(posedge clk) begin
		if (arstN && retire.valid) begin
			if (seen >= NumExp) begin
				$display("Unexpected retire at %0t: r%0d written with %h after the last row",
					$time, retire.rd, retire.data);
				errors++;
			end else begin
				rowOk = 1'b1;
				if (retire.rd !== expRet[seen].rd) begin
					$display("[ERROR] %0t retire.rd expected %0d got %0d",
						$time, expRet[seen].rd, retire.rd);
					rowOk = 1'b0;
				end
				if (retire.data !== expRet[seen].data) begin
					$display("[ERROR] %0t retire.data expected %h got %h",
						$time, expRet[seen].data, retire.data);
					rowOk = 1'b0;
				end
				if (rowOk) begin
					$display("Retire %0d ok: r%0d = %h", seen, retire.rd, retire.data);
				end else begin
					errors++;
				end
				seen++;
			end
		end
	end

endmodule

// ==== sim/cpuCore_assert.sv ====
/* Concurrent checks on the instruction bus and the retire port */
module cpuCoreAssert (
	input logic            clk,
	input logic            arstN,
	input cpuPkg::wbReq_t  ibusReq,
	input cpuPkg::wbRsp_t  ibusRsp,
	input cpuPkg::retire_t retire
);

	int failCount = 0;

	stbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb |-> ibusReq.cyc)
		else begin
			failCount++;
			$error("stb high while cyc is low");
		end

	// Request held with a steady address until ack
	reqHeld: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb && !ibusRsp.ack |=> ibusReq.stb && $stable(ibusReq.adr))
		else begin
			failCount++;
			$error("request dropped or address moved before ack");
		end

	adrStep: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb && ibusRsp.ack |=>
			ibusReq.adr == $past(ibusReq.adr) + 16'(cpuPkg::PcStep))
		else begin
			failCount++;
			$error("address did not advance by one word after ack");
		end

	// First request of the run fetches from address zero
	startAtZero: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ibusReq.cyc) |-> ibusReq.adr == '0)
		else begin
			failCount++;
			$error("first request not at address zero");
		end

	idleAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !ibusReq.cyc)
		else begin
			failCount++;
			$error("cyc high in the first cycle after reset");
		end

	noRetireInReset: assert property (@(posedge clk) !arstN |-> !retire.valid)
		else begin
			failCount++;
			$error("retire valid during reset");
		end

endmodule

// ==== sim/cpuTb.sv ====
/* Testbench top: clock and reset, program table, Wishbone instruction
   memory with random wait states, watchdog and the closing report */
module cpuTb;

	localparam int ClkPeriod = 20;
	localparam int NumRows   = 23;
	localparam int NumExp    = 20;
	localparam int MaxWait   = 3;
	localparam int TimeLimit = NumRows * 8 * ClkPeriod + 2 * ClkPeriod;
	localparam logic [31:0] LfsrSeed = 32'hdfb1_206b;
	localparam logic [15:0] NopWord  = {cpuPkg::OpNop, 11'd0};

	// One program word and the retire it should give
	typedef struct packed {
		logic [15:0] instr;
		logic        retires;
		logic [2:0]  dest;
		logic [15:0] value;
	} row_t;

	logic            clk = 1'b0;
	logic            arstN;
	cpuPkg::wbReq_t  ibusReq;
	cpuPkg::wbRsp_t  ibusRsp = '0;
	cpuPkg::retire_t retire;
	row_t            rows [NumRows];
	cpuPkg::retire_t expRet [NumExp];
	int              seen;
	int              errors;
	int              served = 0;
	logic [1:0]      waitLeft = '0;
	logic [1:0]      nextWait;
	logic [31:0]     lfsr = LfsrSeed;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] iForm(input logic [4:0] op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] rForm(input logic [4:0] op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] lbiForm(input logic [2:0] rs, input logic [7:0] imm);
		return {cpuPkg::OpLbi, rs, imm};
	endfunction

	cpuCore dut_i (.clk, .arstN, .ibusReq, .ibusRsp, .retire);

	cpuChecker #(.NumExp(NumExp)) checker_i (.clk, .arstN, .retire, .expRet, .seen, .errors);

	bind cpuCore cpuCoreAssert assert_i (.clk, .arstN, .ibusReq, .ibusRsp, .retire);

	initial begin
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Instruction memory, one word per ack, NOP past the table
	always @(posedge clk) begin
		if (!arstN) begin
			ibusRsp  <= '0;
			served   <= 0;
			waitLeft <= '0;
		end else if (ibusReq.stb && waitLeft == 0) begin
			lfsr = lfsrNext(lfsr);
			nextWait[0] = lfsr[0];
			lfsr = lfsrNext(lfsr);
			nextWait[1] = lfsr[0];
			ibusRsp.ack <= 1'b1;
			ibusRsp.dat <= (served < NumRows) ? rows[served].instr : NopWord;
			served      <= served + 1;
			waitLeft    <= 2'(int'(nextWait) % (MaxWait + 1));
		end else begin
			ibusRsp.ack <= 1'b0;
			if (ibusReq.stb) begin
				waitLeft <= waitLeft - 2'd1;
			end
		end
	end

	task automatic endRun(input bit timedOut);
		$display("Summary: %0d of %0d retires seen, %0d errors, %0d assertion failures",
			seen, NumExp, errors, dut_i.assert_i.failCount);
		if (timedOut || errors != 0 || seen != NumExp || dut_i.assert_i.failCount != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	endtask

	initial begin
		int k;
		// Reset asserted from time zero
		arstN <= 1'b0;
		// Registers start at zero, values worked out by hand
		rows[0]  = '{lbiForm(3'd1, 8'h80), 1'b1, 3'd1, 16'hFF80};
		rows[1]  = '{lbiForm(3'd2, 8'h05), 1'b1, 3'd2, 16'h0005};
		rows[2]  = '{iForm(cpuPkg::OpAddi, 3'd2, 3'd3, 5'h1D), 1'b1, 3'd3, 16'h0002};
		rows[3]  = '{iForm(cpuPkg::OpSubi, 3'd1, 3'd4, 5'h10), 1'b1, 3'd4, 16'h0070};
		rows[4]  = '{iForm(cpuPkg::OpXori, 3'd1, 3'd5, 5'h1F), 1'b1, 3'd5, 16'hFF9F};
		rows[5]  = '{iForm(cpuPkg::OpAndni, 3'd5, 3'd6, 5'h10), 1'b1, 3'd6, 16'hFF8F};
		// Each one reads the result of the one before
		rows[6]  = '{rForm(cpuPkg::OpAluReg, 3'd6, 3'd4, 3'd7, cpuPkg::Add), 1'b1, 3'd7, 16'hFFFF};
		rows[7]  = '{rForm(cpuPkg::OpAluReg, 3'd7, 3'd2, 3'd1, cpuPkg::Sub), 1'b1, 3'd1, 16'h0006};
		rows[8]  = '{rForm(cpuPkg::OpAluReg, 3'd1, 3'd4, 3'd2, cpuPkg::Xor), 1'b1, 3'd2, 16'h0076};
		// rt written two instructions back
		rows[9]  = '{rForm(cpuPkg::OpAluReg, 3'd2, 3'd1, 3'd3, cpuPkg::AndN), 1'b1, 3'd3, 16'h0070};
		rows[10] = '{NopWord, 1'b0, 3'd0, 16'h0000};
		rows[11] = '{iForm(cpuPkg::OpRoli, 3'd3, 3'd4, 5'h0F), 1'b1, 3'd4, 16'h0038};
		rows[12] = '{iForm(cpuPkg::OpSlli, 3'd7, 3'd5, 5'h0F), 1'b1, 3'd5, 16'h8000};
		rows[13] = '{iForm(cpuPkg::OpRori, 3'd1, 3'd6, 5'h03), 1'b1, 3'd6, 16'hC000};
		rows[14] = '{iForm(cpuPkg::OpSrli, 3'd6, 3'd7, 5'h0F), 1'b1, 3'd7, 16'h0001};
		rows[15] = '{NopWord, 1'b0, 3'd0, 16'h0000};
		rows[16] = '{rForm(cpuPkg::OpShiftReg, 3'd2, 3'd5, 3'd1, cpuPkg::Rol), 1'b1, 3'd1, 16'h0076};
		rows[17] = '{rForm(cpuPkg::OpShiftReg, 3'd1, 3'd7, 3'd2, cpuPkg::Sll), 1'b1, 3'd2, 16'h00EC};
		rows[18] = '{rForm(cpuPkg::OpShiftReg, 3'd1, 3'd4, 3'd3, cpuPkg::Ror), 1'b1, 3'd3, 16'h7600};
		rows[19] = '{rForm(cpuPkg::OpShiftReg, 3'd3, 3'd2, 3'd4, cpuPkg::Srl), 1'b1, 3'd4, 16'h0007};
		rows[20] = '{rForm(cpuPkg::OpShiftReg, 3'd5, 3'd4, 3'd5, cpuPkg::Ror), 1'b1, 3'd5, 16'h0100};
		// Opcode outside the kept set
		rows[21] = '{16'h0000, 1'b0, 3'd0, 16'h0000};
		rows[22] = '{iForm(cpuPkg::OpAddi, 3'd5, 3'd6, 5'h01), 1'b1, 3'd6, 16'h0101};

		k = 0;
		for (int i = 0; i < NumRows; i++) begin
			if (rows[i].retires) begin
				expRet[k] = '{valid: 1'b1, rd: rows[i].dest, data: rows[i].value};
				k++;
			end
		end

		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		wait (seen == NumExp);
		// Drain so that a stray retire still shows up
		repeat (8) @(posedge clk);
		endRun(1'b0);
	end

	initial begin
		#(TimeLimit);
		$display("Timeout: %0d of %0d expected retires never arrived", NumExp - seen, NumExp);
		endRun(1'b1);
	end

endmodule
